// ==== Bender.yml ====
package:
  name: e100_cpu

sources:
  - files:
      - logic/e100_pkg.sv
      - logic/e100_alu.sv
      - logic/e100_memory.sv
      - logic/e100_datapath.sv
      - logic/e100_control.sv
      - logic/e100_cpu.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/e100_cpu_tb.sv

// ==== e100_cpu.f ====
+incdir+verification
logic/e100_pkg.sv
logic/e100_alu.sv
logic/e100_memory.sv
logic/e100_datapath.sv
logic/e100_control.sv
logic/e100_cpu.sv
verification/e100_cpu_tb.sv

// ==== logic/e100_alu.sv ====
// combinational; shifts are logical and give zero for amounts of 32 or more
`timescale 1ns/1ps
`default_nettype none

module e100_alu (
    input  wire e100_pkg::opcode_t opcode,
    input  wire e100_pkg::word_t   op1,
    input  wire e100_pkg::word_t   op2,
    output e100_pkg::word_t        result,
    output logic                   equal,
    output logic                   less
);
    import e100_pkg::*;

    always_comb begin
        case (opcode)
            op_add:  result = op1 + op2;
            // wraps modulo 2**32
            op_sub:  result = op1 - op2;
            op_and:  result = op1 & op2;
            op_or:   result = op1 | op2;
            op_not:  result = ~op1;
            // full 32-bit shift amount
            op_sl:   result = op1 << op2;
            op_sr:   result = op1 >> op2;
            default: result = '0;
        endcase
    end

    // branch flags
    assign equal = (op1 == op2);
    assign less  = ($signed(op1) < $signed(op2));

endmodule

`default_nettype wire

// ==== logic/e100_control.sv ====
// one bus transfer per state; unknown opcodes return to fetch, halt never leaves
`timescale 1ns/1ps
`default_nettype none

module e100_control (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire e100_pkg::opcode_t    opcode,
    input  wire logic                 equal,
    input  wire logic                 less,
    output e100_pkg::bus_source_t     bus_source,
    output logic                      iar_write,
    output logic                      address_write,
    output logic                      opcode_write,
    output logic                      arg1_write,
    output logic                      arg2_write,
    output logic                      arg3_write,
    output logic                      op1_write,
    output logic                      op2_write,
    output logic                      memory_write,
    output logic                      halted
);
    import e100_pkg::*;

    state_t state;
    state_t next_state;
    logic   taken;

    // branch condition picked by the latched opcode
    always_comb begin
        case (opcode)
            op_be:   taken = equal;
            op_bne:  taken = ~equal;
            op_blt:  taken = less;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        bus_source    = bus_none;
        iar_write     = 1'b0;
        address_write = 1'b0;
        opcode_write  = 1'b0;
        arg1_write    = 1'b0;
        arg2_write    = 1'b0;
        arg3_write    = 1'b0;
        op1_write     = 1'b0;
        op2_write     = 1'b0;
        memory_write  = 1'b0;
        next_state    = state_reset;

        case (state)
            state_reset: next_state = state_fetch1;

            // opcode and three argument words
            state_fetch1: begin
                bus_source    = bus_iar;
                address_write = 1'b1;
                next_state    = state_fetch2;
            end
            state_fetch2: begin
                bus_source   = bus_memory;
                opcode_write = 1'b1;
                next_state   = state_fetch3;
            end
            state_fetch3, state_fetch5, state_fetch7: begin
                // step iar and point memory at the next word
                bus_source    = bus_plus1;
                iar_write     = 1'b1;
                address_write = 1'b1;
                next_state    = (state == state_fetch3) ? state_fetch4
                              : (state == state_fetch5) ? state_fetch6 : state_fetch8;
            end
            state_fetch4: begin
                bus_source = bus_memory;
                arg1_write = 1'b1;
                next_state = state_fetch5;
            end
            state_fetch6: begin
                bus_source = bus_memory;
                arg2_write = 1'b1;
                next_state = state_fetch7;
            end
            state_fetch8: begin
                bus_source = bus_memory;
                arg3_write = 1'b1;
                next_state = state_decode;
            end

            state_decode: begin
                // iar now points past arg3
                bus_source = bus_plus1;
                iar_write  = 1'b1;
                case (opcode)
                    op_halt:                                    next_state = state_halt;
                    op_add, op_sub, op_and, op_or, op_sl, op_sr: next_state = state_alu1;
                    op_not:                                     next_state = state_not1;
                    op_cp:                                      next_state = state_cp1;
                    op_be, op_bne, op_blt:                      next_state = state_branch1;
                    default:                                    next_state = state_fetch1;
                endcase
            end

            state_halt: next_state = state_halt;

            // operand loads, common to alu and branch sequences
            state_alu1, state_branch1, state_not1, state_cp1: begin
                bus_source    = bus_arg2;
                address_write = 1'b1;
                next_state    = (state == state_alu1) ? state_alu2
                              : (state == state_branch1) ? state_branch2
                              : (state == state_not1) ? state_not2 : state_cp2;
            end
            state_alu2, state_branch2, state_not2: begin
                bus_source = bus_memory;
                op1_write  = 1'b1;
                next_state = (state == state_alu2) ? state_alu3
                           : (state == state_branch2) ? state_branch3 : state_not3;
            end
            state_alu3, state_branch3: begin
                bus_source    = bus_arg3;
                address_write = 1'b1;
                next_state    = (state == state_alu3) ? state_alu4 : state_branch4;
            end
            state_alu4, state_branch4: begin
                bus_source = bus_memory;
                op2_write  = 1'b1;
                next_state = (state == state_alu4) ? state_alu5 : state_branch5;
            end

            // destination address, then store
            state_alu5, state_not3, state_cp3: begin
                bus_source    = bus_arg1;
                address_write = 1'b1;
                next_state    = (state == state_alu5) ? state_alu6
                              : (state == state_not3) ? state_not4 : state_cp4;
            end
            state_alu6, state_not4: begin
                bus_source   = bus_alu;
                memory_write = 1'b1;
                next_state   = state_fetch1;
            end

            // arg3 is free after fetch, so cp parks the word there
            state_cp2: begin
                bus_source = bus_memory;
                arg3_write = 1'b1;
                next_state = state_cp3;
            end
            state_cp4: begin
                bus_source   = bus_arg3;
                memory_write = 1'b1;
                next_state   = state_fetch1;
            end

            state_branch5: next_state = taken ? state_branch6 : state_fetch1;
            state_branch6: begin
                bus_source = bus_arg1;
                iar_write  = 1'b1;
                next_state = state_fetch1;
            end

            default: next_state = state_reset;
        endcase
    end

    assign halted = (state == state_halt);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= state_reset;
        end else begin
            state <= next_state;
        end
    end

endmodule

`default_nettype wire

// ==== logic/e100_cpu.sv ====
// load the program only while reset is high; store and load strobes have no back-pressure
`timescale 1ns/1ps
`default_nettype none

module e100_cpu (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire logic               load_valid,
    input  wire e100_pkg::address_t load_address,
    input  wire e100_pkg::word_t    load_data,
    output logic                    halted,
    output logic                    store_valid,
    output e100_pkg::address_t      store_address,
    output e100_pkg::word_t         store_data
);
    import e100_pkg::*;

    bus_source_t bus_source;
    logic        iar_write;
    logic        address_write;
    logic        opcode_write;
    logic        arg1_write;
    logic        arg2_write;
    logic        arg3_write;
    logic        op1_write;
    logic        op2_write;
    logic        memory_write;
    word_t       bus;
    address_t    address;
    opcode_t     opcode;
    word_t       op1;
    word_t       op2;
    word_t       memory_data;
    word_t       alu_result;
    logic        equal;
    logic        less;

    e100_control u_control (
        .clock         (clock),
        .reset         (reset),
        .opcode        (opcode),
        .equal         (equal),
        .less          (less),
        .bus_source    (bus_source),
        .iar_write     (iar_write),
        .address_write (address_write),
        .opcode_write  (opcode_write),
        .arg1_write    (arg1_write),
        .arg2_write    (arg2_write),
        .arg3_write    (arg3_write),
        .op1_write     (op1_write),
        .op2_write     (op2_write),
        .memory_write  (memory_write),
        .halted        (halted)
    );

    e100_datapath u_datapath (
        .clock         (clock),
        .reset         (reset),
        .bus_source    (bus_source),
        .iar_write     (iar_write),
        .address_write (address_write),
        .opcode_write  (opcode_write),
        .arg1_write    (arg1_write),
        .arg2_write    (arg2_write),
        .arg3_write    (arg3_write),
        .op1_write     (op1_write),
        .op2_write     (op2_write),
        .memory_data   (memory_data),
        .alu_result    (alu_result),
        .bus           (bus),
        .address       (address),
        .opcode        (opcode),
        .op1           (op1),
        .op2           (op2)
    );

    e100_alu u_alu (
        .opcode (opcode),
        .op1    (op1),
        .op2    (op2),
        .result (alu_result),
        .equal  (equal),
        .less   (less)
    );

    e100_memory u_memory (
        .clock        (clock),
        .address      (address),
        .write_data   (bus),
        .memory_write (memory_write),
        .load_valid   (load_valid),
        .load_address (load_address),
        .load_data    (load_data),
        .read_data    (memory_data)
    );

    // every bus write to memory shows up on the store port
    assign store_valid   = memory_write;
    assign store_address = address;
    assign store_data    = bus;

endmodule

`default_nettype wire

// ==== logic/e100_datapath.sv ====
// single bus, one driver per cycle; address register keeps only the low 8 bus bits
`timescale 1ns/1ps
`default_nettype none

module e100_datapath (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire e100_pkg::bus_source_t bus_source,
    input  wire logic                  iar_write,
    input  wire logic                  address_write,
    input  wire logic                  opcode_write,
    input  wire logic                  arg1_write,
    input  wire logic                  arg2_write,
    input  wire logic                  arg3_write,
    input  wire logic                  op1_write,
    input  wire logic                  op2_write,
    input  wire e100_pkg::word_t       memory_data,
    input  wire e100_pkg::word_t       alu_result,
    output e100_pkg::word_t            bus,
    output e100_pkg::address_t         address,
    output e100_pkg::opcode_t          opcode,
    output e100_pkg::word_t            op1,
    output e100_pkg::word_t            op2
);
    import e100_pkg::*;

    word_t iar;
    word_t iar_plus1;
    word_t arg1;
    word_t arg2;
    word_t arg3;

    assign iar_plus1 = iar + word_t'(1);

    // bus multiplexer
    always_comb begin
        case (bus_source)
            bus_iar:    bus = iar;
            bus_plus1:  bus = iar_plus1;
            bus_memory: bus = memory_data;
            bus_arg1:   bus = arg1;
            bus_arg2:   bus = arg2;
            bus_arg3:   bus = arg3;
            bus_alu:    bus = alu_result;
            default:    bus = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            iar     <= '0;
            address <= '0;
            opcode  <= op_halt;
            arg1    <= '0;
            arg2    <= '0;
            arg3    <= '0;
            op1     <= '0;
            op2     <= '0;
        end else begin
            if (iar_write) begin
                iar <= bus;
            end
            if (address_write) begin
                address <= bus[7:0];
            end
            // any 32-bit value may land here, unknown ones decode as no-ops
            if (opcode_write) begin
                opcode <= opcode_t'(bus);
            end
            if (arg1_write) begin
                arg1 <= bus;
            end
            if (arg2_write) begin
                arg2 <= bus;
            end
            if (arg3_write) begin
                arg3 <= bus;
            end
            if (op1_write) begin
                op1 <= bus;
            end
            if (op2_write) begin
                op2 <= bus;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/e100_memory.sv ====
// contents survive reset; a load strobe wins over a bus write in the same cycle
`timescale 1ns/1ps
`default_nettype none

module e100_memory (
    input  wire logic               clock,
    input  wire e100_pkg::address_t address,
    input  wire e100_pkg::word_t    write_data,
    input  wire logic               memory_write,
    input  wire logic               load_valid,
    input  wire e100_pkg::address_t load_address,
    input  wire e100_pkg::word_t    load_data,
    output e100_pkg::word_t         read_data
);
    import e100_pkg::*;

    word_t mem [MEM_DEPTH];

    // asynchronous read from the address register
    assign read_data = mem[address];

    always_ff @(posedge clock) begin
        if (load_valid) begin
            // program load port
            mem[load_address] <= load_data;
        end else if (memory_write) begin
            mem[address] <= write_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/e100_pkg.sv ====
// word and address widths are fixed; opcodes outside opcode_t fall through to fetch as no-ops
`default_nettype none

package e100_pkg;

    // one bus or memory word
    typedef logic [31:0] word_t;

    // memory word address, low byte of the bus
    typedef logic [7:0] address_t;

    localparam int MEM_DEPTH = 256;

    // E100 opcodes kept in this core
    typedef enum logic [31:0] {
        op_halt = 32'd0,
        op_add  = 32'd1,
        op_sub  = 32'd2,
        op_cp   = 32'd5,
        op_and  = 32'd6,
        op_or   = 32'd7,
        op_not  = 32'd8,
        op_sl   = 32'd9,
        op_sr   = 32'd10,
        op_be   = 32'd13,
        op_bne  = 32'd14,
        op_blt  = 32'd15
    } opcode_t;

    // alu states are shared by all two-operand instructions,
    // branch states by be, bne and blt
    typedef enum logic [4:0] {
        state_reset,
        state_fetch1, state_fetch2, state_fetch3, state_fetch4,
        state_fetch5, state_fetch6, state_fetch7, state_fetch8,
        state_decode,
        state_halt,
        state_alu1, state_alu2, state_alu3, state_alu4, state_alu5, state_alu6,
        state_not1, state_not2, state_not3, state_not4,
        state_cp1, state_cp2, state_cp3, state_cp4,
        state_branch1, state_branch2, state_branch3,
        state_branch4, state_branch5, state_branch6
    } state_t;

    // the one register or unit that drives the bus this cycle
    typedef enum logic [2:0] {
        bus_none,
        bus_iar,
        bus_plus1,
        bus_memory,
        bus_arg1,
        bus_arg2,
        bus_arg3,
        bus_alu
    } bus_source_t;

endpackage

`default_nettype wire

// ==== verification/e100_cpu_tb_cases.svh ====
// included inside e100_cpu_tb only; operand words are ignored when the random flag is set
`ifndef E100_CPU_TB_CASES_SVH
`define E100_CPU_TB_CASES_SVH

// columns: opcode, op1 word, op2 word, random operands, outcome
task automatic build_case_table();
    add_case(op_add, 32'd5,          32'd7,          1'b0, outcome_store);
    add_case(op_add, 32'hffff_ffff,  32'd1,          1'b0, outcome_store);
    add_case(op_add, 32'd0,          32'd0,          1'b1, outcome_store);
    add_case(op_sub, 32'd10,         32'd3,          1'b0, outcome_store);
    // wraps below zero
    add_case(op_sub, 32'd3,          32'd10,         1'b0, outcome_store);
    add_case(op_and, 32'hf0f0_ff00,  32'h3c3c_0ff0,  1'b0, outcome_store);
    add_case(op_or,  32'hf0f0_0000,  32'h0000_3c3c,  1'b0, outcome_store);
    add_case(op_and, 32'd0,          32'd0,          1'b1, outcome_store);
    add_case(op_not, 32'h0f0f_00ff,  32'd0,          1'b0, outcome_store);
    add_case(op_not, 32'd0,          32'd0,          1'b1, outcome_store);
    add_case(op_cp,  32'h1234_5678,  32'd0,          1'b0, outcome_store);
    add_case(op_cp,  32'd0,          32'd0,          1'b1, outcome_store);

    // shift amounts 0, 31 and 40
    add_case(op_sl,  32'h8000_0001,  32'd0,          1'b0, outcome_store);
    add_case(op_sl,  32'h0000_0003,  32'd31,         1'b0, outcome_store);
    add_case(op_sl,  32'hffff_ffff,  32'd40,         1'b0, outcome_store);
    add_case(op_sr,  32'h8000_0001,  32'd0,          1'b0, outcome_store);
    add_case(op_sr,  32'hc000_0000,  32'd31,         1'b0, outcome_store);
    add_case(op_sr,  32'hffff_ffff,  32'd40,         1'b0, outcome_store);

    add_case(op_be,  32'h0000_abcd,  32'h0000_abcd,  1'b0, outcome_taken);
    add_case(op_be,  32'h0000_abcd,  32'h0000_abce,  1'b0, outcome_not_taken);
    add_case(op_bne, 32'h5555_5555,  32'h5555_5555,  1'b0, outcome_not_taken);
    add_case(op_bne, 32'h5555_5555,  32'haaaa_aaaa,  1'b0, outcome_taken);
    // -5 against 3, signed compare
    add_case(op_blt, 32'hffff_fffb,  32'd3,          1'b0, outcome_taken);
    add_case(op_blt, 32'd3,          32'hffff_fffb,  1'b0, outcome_not_taken);
    add_case(op_blt, 32'd7,          32'd9,          1'b0, outcome_taken);
    add_case(op_blt, 32'd9,          32'd9,          1'b0, outcome_not_taken);

    // mult and an opcode far outside the set
    add_case(32'd3,  32'd1,          32'd2,          1'b0, outcome_skip);
    add_case(32'hdead_beef, 32'd1,   32'd2,          1'b0, outcome_skip);
endtask

`endif

// ==== verification/e100_cpu_tb.sv ====
// one program per case, loaded while reset is high; needs verification/ on the include path
`timescale 1ns/1ps
`default_nettype none

module e100_cpu_tb;
    import e100_pkg::*;

    localparam int CLOCK_PERIOD = 40;
    localparam int RESET_CYCLES = 4;
    localparam int IMAGE_WORDS = 24;
    localparam int FETCH_DECODE_CYCLES = 9;
    localparam int RUN_LIMIT = 40;
    localparam int CASE_CYCLES = 60;
    localparam int WATCHDOG_MARGIN = 200;
    localparam address_t SOURCE1 = 8'd20;
    localparam address_t SOURCE2 = 8'd21;
    localparam address_t DEST = 8'd22;
    localparam address_t TARGET = 8'd8;

    typedef enum logic [1:0] {
        outcome_store,
        outcome_taken,
        outcome_not_taken,
        outcome_skip
    } outcome_t;

    logic     clock;
    logic     reset;
    logic     load_valid;
    address_t load_address;
    word_t    load_data;
    logic     halted;
    logic     store_valid;
    address_t store_address;
    word_t    store_data;

    word_t    case_opcode [$];
    word_t    case_first [$];
    word_t    case_second [$];
    bit       case_random [$];
    outcome_t case_outcome [$];
    word_t    image [IMAGE_WORDS];
    int       error_count;
    int       seed;

    task automatic add_case(input word_t opcode, input word_t first, input word_t second,
                            input bit random_operands, input outcome_t outcome);
        case_opcode.push_back(opcode);
        case_first.push_back(first);
        case_second.push_back(second);
        case_random.push_back(random_operands);
        case_outcome.push_back(outcome);
    endtask

    `include "e100_cpu_tb_cases.svh"

    e100_cpu DUT (
        .clock         (clock),
        .reset         (reset),
        .load_valid    (load_valid),
        .load_address  (load_address),
        .load_data     (load_data),
        .halted        (halted),
        .store_valid   (store_valid),
        .store_address (store_address),
        .store_data    (store_data)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // reference model of the stored word
    function automatic word_t expected_word(input word_t opcode, input word_t a, input word_t b);
        case (opcode)
            op_add:  return a + b;
            op_sub:  return a + ~b + 32'd1;
            op_and:  return a & b;
            op_or:   return a | b;
            op_not:  return a ^ 32'hffff_ffff;
            op_cp:   return a;
            op_sl:   return (b > 32'd31) ? 32'd0 : (a << b[4:0]);
            op_sr:   return (b > 32'd31) ? 32'd0 : (a >> b[4:0]);
            default: return 32'd0;
        endcase
    endfunction

    function automatic int execute_cycles(input word_t opcode, input outcome_t outcome);
        case (outcome)
            outcome_taken:     return 6;
            outcome_not_taken: return 5;
            outcome_skip:      return 0;
            default:           return (opcode == op_not || opcode == op_cp) ? 4 : 6;
        endcase
    endfunction

    task automatic prepare_image(input word_t opcode, input word_t a, input word_t b,
                                 input outcome_t outcome);
        int i;
        for (i = 0; i < IMAGE_WORDS; i++) begin
            image[i] = 32'hc0de_0000 | (i * 32'h0000_0101);
        end
        image[0] = opcode;
        image[1] = (outcome == outcome_taken || outcome == outcome_not_taken) ? TARGET : DEST;
        image[2] = SOURCE1;
        image[3] = SOURCE2;
        // halt at 4 for fall-through, halt at 8 for the branch target
        image[4] = op_halt;
        image[8] = op_halt;
        image[SOURCE1] = a;
        image[SOURCE2] = b;
    endtask

    task automatic run_case(input int index);
        word_t    opcode;
        word_t    first;
        word_t    second;
        outcome_t outcome;
        int       i;
        int       cycles;
        int       exec;
        int       store_count;
        int       store_cycle;
        address_t seen_address;
        word_t    seen_data;
        opcode  = case_opcode[index];
        first   = case_first[index];
        second  = case_second[index];
        outcome = case_outcome[index];
        if (case_random[index]) begin
            first  = $urandom;
            second = $urandom;
        end
        prepare_image(opcode, first, second, outcome);
        @(posedge clock);
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        if (halted !== 1'b0) begin
            error_count++;
            $display("error halted expected 0x0 got 0x%h in reset (case %0d)", halted, index);
        end
        if (store_valid !== 1'b0) begin
            error_count++;
            $display("error store_valid expected 0x0 got 0x%h in reset (case %0d)",
                     store_valid, index);
        end
        for (i = 0; i < IMAGE_WORDS; i++) begin
            @(posedge clock);
            load_valid   <= 1'b1;
            load_address <= address_t'(i);
            load_data    <= image[i];
        end
        @(posedge clock);
        load_valid <= 1'b0;
        reset      <= 1'b0;

        // reset state is cycle 0
        cycles      = 0;
        store_count = 0;
        store_cycle = -1;
        @(negedge clock);
        while (!halted && cycles < RUN_LIMIT) begin
            @(posedge clock);
            cycles++;
            @(negedge clock);
            if (store_valid) begin
                store_count++;
                store_cycle  = cycles;
                seen_address = store_address;
                seen_data    = store_data;
            end
        end

        exec = execute_cycles(opcode, outcome);
        if (!halted) begin
            error_count++;
            $display("case %0d: halted never rose within %0d cycles", index, RUN_LIMIT);
        end else if (cycles != 1 + 2 * FETCH_DECODE_CYCLES + exec) begin
            error_count++;
            $display("case %0d: halted rose after %0d cycles instead of %0d", index, cycles,
                     1 + 2 * FETCH_DECODE_CYCLES + exec);
        end
        if (outcome != outcome_store && store_count != 0) begin
            error_count++;
            $display("case %0d: %0d stores seen where none belong", index, store_count);
        end
        if (outcome == outcome_store && store_count != 1) begin
            error_count++;
            $display("case %0d: %0d stores seen instead of one", index, store_count);
        end
        if (outcome == outcome_store && store_count == 1) begin
            if (seen_address !== DEST) begin
                error_count++;
                $display("error store_address expected 0x%h got 0x%h (case %0d)",
                         DEST, seen_address, index);
            end
            if (seen_data !== expected_word(opcode, first, second)) begin
                error_count++;
                $display("error store_data expected 0x%h got 0x%h (case %0d)",
                         expected_word(opcode, first, second), seen_data, index);
            end
            // store falls in the last execute cycle
            if (store_cycle != FETCH_DECODE_CYCLES + exec) begin
                error_count++;
                $display("case %0d: store came in cycle %0d instead of %0d", index,
                         store_cycle, FETCH_DECODE_CYCLES + exec);
            end
        end
    endtask

    initial begin
        int index;
        reset        <= 1'b1;
        load_valid   <= 1'b0;
        load_address <= '0;
        load_data    <= '0;
        error_count  = 0;
        seed         = 25;
        void'($urandom(seed));
        build_case_table();
        for (index = 0; index < case_opcode.size(); index++) begin
            run_case(index);
        end
        @(posedge clock);
        $display("cases %0d errors %0d", case_opcode.size(), error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // bounds the whole run by the size of the case table
    initial begin
        int limit;
        #1;
        limit = case_opcode.size() * CASE_CYCLES + WATCHDOG_MARGIN;
        repeat (limit) @(posedge clock);
        $display("watchdog expired after %0d cycles before all cases finished", limit);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
